//--- project.f
+incdir+dv
rtl/noc_pkg.sv
rtl/flit_fifo.sv
rtl/vc_output_arbiter.sv
rtl/vc_selector.sv
dv/vc_selector_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module vc_selector_tb -f project.f -o vc_selector_sim \
  && ./obj_dir/vc_selector_sim | tee sim.log \
  || { echo "Build or simulation did not run to the end"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
  && { echo "Testbench reported failure"; exit 1; } \
  || { echo "Testbench reported no failure"; exit 0; }

//--- dv/vc_scoreboard.svh
`ifndef VC_SCOREBOARD_SVH
`define VC_SCOREBOARD_SVH

// Flits in flight per channel, oldest first.
flit_t  exp_q [vc_count][$];
flit_t  held_flit;
logic   held_pending = 1'b0;
logic   in_packet = 1'b0;
vc_id_t packet_vc = '0;

function automatic int outstanding();
  int total;
  total = 0;
  for (int i = 0; i < vc_count; i++) begin
    total += exp_q[i].size();
  end
  return total;
endfunction

task automatic check_reset_outputs();
  if (out_valid !== 1'b0) begin
    errors++;
    $display("[FAIL] out_valid: expected %h, actual %h", 1'b0, out_valid);
  end
  if (in_ready !== 1'b1) begin
    errors++;
    $display("[FAIL] in_ready: expected %h, actual %h", 1'b1, in_ready);
  end
endtask

// Full channel refuses the link, others take it.
task automatic check_input();
  logic full;
  if (in_valid) begin
    full = exp_q[in_flit.vc].size() >= fifo_depth;
    if (in_ready !== !full) begin
      errors++;
      $display("[FAIL] in_ready: expected %h, actual %h (channel %0d)",
               !full, in_ready, in_flit.vc);
    end
    if (in_ready) begin
      exp_q[in_flit.vc].push_back(in_flit);
      in_count++;
    end
  end
endtask

// A stalled flit must still be there one cycle later.
task automatic check_hold();
  if (held_pending) begin
    if (out_valid !== 1'b1) begin
      errors++;
      $display("[FAIL] out_valid: expected %h, actual %h", 1'b1, out_valid);
    end else if (out_flit !== held_flit) begin
      errors++;
      $display("[FAIL] out_flit: expected %h, actual %h", held_flit, out_flit);
    end
  end
  held_pending = out_valid && !out_ready;
  held_flit    = out_flit;
endtask

task automatic check_output();
  flit_t expected;
  if (out_valid && out_ready) begin
    out_count++;
    if (exp_q[out_flit.vc].size() == 0) begin
      errors++;
      $display("Output sent a flit on channel %0d with nothing outstanding there", out_flit.vc);
    end else begin
      expected = exp_q[out_flit.vc].pop_front();
      if (out_flit !== expected) begin
        errors++;
        $display("[FAIL] out_flit: expected %h, actual %h", expected, out_flit);
      end
    end
    if (in_packet && (out_flit.vc != packet_vc ||
        out_flit.kind == flit_head || out_flit.kind == flit_single)) begin
      errors++;
      $display("Packet on channel %0d was broken by a kind %0d flit from channel %0d",
               packet_vc, out_flit.kind, out_flit.vc);
    end else if (!in_packet && (out_flit.kind == flit_body || out_flit.kind == flit_tail)) begin
      errors++;
      $display("A kind %0d flit left channel %0d outside any packet",
               out_flit.kind, out_flit.vc);
    end
    if (out_flit.kind == flit_tail || out_flit.kind == flit_single) begin
      in_packet = 1'b0;
    end else if (out_flit.kind == flit_head) begin
      in_packet = 1'b1;
      packet_vc = out_flit.vc;
    end
  end
endtask

task automatic check_drained();
  for (int i = 0; i < vc_count; i++) begin
    if (exp_q[i].size() != 0) begin
      errors++;
      $display("Channel %0d still holds %0d undelivered flits", i, exp_q[i].size());
    end
  end
  if (out_count != in_count) begin
    errors++;
    $display("Output delivered %0d flits but the input accepted %0d", out_count, in_count);
  end
endtask

`endif

//--- dv/vc_selector_tb.sv
`timescale 1ns/1ps

module vc_selector_tb;
  import noc_pkg::*;

  localparam int num_packets    = 300;
  localparam int max_flits      = 4;
  localparam int timeout_cycles = num_packets * max_flits * 8;
  localparam int quiet_cycles   = 16;

  logic   clk;
  logic   reset;
  logic   in_valid;
  flit_t  in_flit;
  logic   in_ready;
  logic   out_valid;
  flit_t  out_flit;
  logic   out_ready;

  integer seed;
  int     errors = 0;
  int     in_count = 0;
  int     out_count = 0;
  int     cycle_count = 0;
  int     idle_cycles = 0;
  int     packets_started = 0;
  int     flits_left [vc_count];
  logic   in_fire = 1'b0;

  `include "vc_scoreboard.svh"

  vc_selector uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not complete within %0d cycles", timeout_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Mid-cycle, so the values seen are the ones the next edge takes.
  always @(negedge clk) begin
    in_fire = !reset && in_valid && in_ready;
    if (!reset) begin
      check_hold();
      check_input();
      check_output();
    end
  end

  function automatic logic other_open(int c);
    logic open;
    open = 1'b0;
    for (int i = 0; i < vc_count; i++) begin
      if (i != c && flits_left[i] != 0) begin
        open = 1'b1;
      end
    end
    return open;
  endfunction

  // A full channel is only offered when no other packet is half sent.
  // Otherwise its tail could sit behind the blocked flit for good.
  function automatic logic can_offer(int c);
    return (flits_left[c] != 0 || packets_started < num_packets) &&
           (exp_q[c].size() < fifo_depth || !other_open(c));
  endfunction

  task automatic offer_flit();
    int   start;
    int   c;
    int   len;
    logic found;
    found = 1'b0;
    c     = 0;
    if (!in_valid || in_fire) begin
      in_valid = 1'b0;
      start = int'({$random(seed)} % vc_count);
      for (int k = 0; k < vc_count; k++) begin
        if (!found && can_offer((start + k) % vc_count)) begin
          found = 1'b1;
          c     = (start + k) % vc_count;
        end
      end
      if (found && ({$random(seed)} % 8) != 0) begin
        if (flits_left[c] == 0) begin
          len = 1 + int'({$random(seed)} % max_flits);
          packets_started++;
          in_flit.kind  = (len == 1) ? flit_single : flit_head;
          flits_left[c] = len;
        end else begin
          in_flit.kind = (flits_left[c] == 1) ? flit_tail : flit_body;
        end
        flits_left[c]--;
        in_flit.vc      = vc_id_t'(c);
        in_flit.payload = $random(seed);
        in_valid        = 1'b1;
      end
    end
  endtask

  function automatic logic stimulus_done();
    logic done;
    done = (packets_started == num_packets) && !in_valid;
    for (int i = 0; i < vc_count; i++) begin
      if (flits_left[i] != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    seed      = 32'hc67bbcc9;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_flit   = '0;
    out_ready = 1'b0;
    for (int i = 0; i < vc_count; i++) begin
      flits_left[i] = 0;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    #1;
    check_reset_outputs();
    while (!stimulus_done()) begin
      @(posedge clk);
      #1;
      out_ready = ({$random(seed)} % 10) < 7;
      offer_flit();
    end
    // Done when the queues drain or the output link stays idle.
    while (outstanding() != 0 && idle_cycles < quiet_cycles) begin
      @(posedge clk);
      #1;
      if (out_valid) begin
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
      out_ready = ({$random(seed)} % 10) < 7;
    end
    repeat (4) @(posedge clk);
    #1;
    check_drained();
    $display("errors: %0d, flits in: %0d, flits out: %0d", errors, in_count, out_count);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/vc_selector.sv
`timescale 1ns/1ps

module vc_selector (
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  noc_pkg::flit_t in_flit,
  output logic           in_ready,
  output logic           out_valid,
  output noc_pkg::flit_t out_flit,
  input  logic           out_ready
);
  import noc_pkg::*;

  vc_mask_t fifo_in_valid;
  vc_mask_t fifo_in_ready;
  vc_mask_t fifo_valid;
  vc_mask_t fifo_ready;
  flit_t    fifo_flit [vc_count];

  // Channel number picks the write side.
  always_comb begin
    fifo_in_valid = '0;
    fifo_in_valid[in_flit.vc] = in_valid;
  end

  // A full channel stalls the whole link.
  assign in_ready = fifo_in_ready[in_flit.vc];

  for (genvar i = 0; i < vc_count; i++) begin : g_fifo
    flit_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (fifo_in_valid[i]),
      .in_flit   (in_flit),
      .in_ready  (fifo_in_ready[i]),
      .out_valid (fifo_valid[i]),
      .out_flit  (fifo_flit[i]),
      .out_ready (fifo_ready[i])
    );
  end

  vc_output_arbiter u_arbiter (
    .clk        (clk),
    .reset      (reset),
    .fifo_valid (fifo_valid),
    .fifo_flit  (fifo_flit),
    .fifo_ready (fifo_ready),
    .out_valid  (out_valid),
    .out_flit   (out_flit),
    .out_ready  (out_ready)
  );

endmodule

//--- rtl/vc_output_arbiter.sv
`timescale 1ns/1ps

module vc_output_arbiter (
  input  logic              clk,
  input  logic              reset,
  input  noc_pkg::vc_mask_t fifo_valid,
  input  noc_pkg::flit_t    fifo_flit [noc_pkg::vc_count],
  output noc_pkg::vc_mask_t fifo_ready,
  output logic              out_valid,
  output noc_pkg::flit_t    out_flit,
  input  logic              out_ready
);
  import noc_pkg::*;

  arb_state_t state;
  vc_mask_t   grant;
  vc_id_t     grant_vc;
  vc_id_t     last_vc;

  vc_mask_t   request;
  logic       pick_valid;
  vc_id_t     pick_vc;
  vc_mask_t   pick_mask;
  logic       tail_done;

  // A channel asks for the link only with a head at its front.
  always_comb begin
    for (int i = 0; i < vc_count; i++) begin
      request[i] = fifo_valid[i] && is_head(fifo_flit[i].kind);
    end
  end

  // Round robin, starting just after the last granted channel.
  always_comb begin
    vc_id_t cand;
    pick_valid = 1'b0;
    pick_vc    = last_vc;
    for (int off = 1; off <= vc_count; off++) begin
      cand = vc_id_t'((int'(last_vc) + off) % vc_count);
      if (!pick_valid && request[cand]) begin
        pick_valid = 1'b1;
        pick_vc    = cand;
      end
    end
  end

  always_comb begin
    pick_mask = '0;
    if (pick_valid) begin
      pick_mask[pick_vc] = 1'b1;
    end
  end

  // Granted channel straight through to the link.
  assign out_valid  = (state == arb_busy) && |(fifo_valid & grant);
  assign fifo_ready = (state == arb_busy) ? (grant & {vc_count{out_ready}}) : '0;

  always_comb begin
    out_flit = '0;
    for (int i = 0; i < vc_count; i++) begin
      if (grant[i]) begin
        out_flit = fifo_flit[i];
      end
    end
  end

  assign tail_done = out_valid && out_ready && is_tail(out_flit.kind);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= arb_idle;
      grant    <= '0;
      grant_vc <= '0;
      // Channel 0 wins first.
      last_vc  <= vc_id_t'(vc_count - 1);
    end else begin
      case (state)
        arb_idle: begin
          if (pick_valid) begin
            state    <= arb_busy;
            grant    <= pick_mask;
            grant_vc <= pick_vc;
          end
        end
        arb_busy: begin
          // Hold until the tail leaves.
          if (tail_done) begin
            state   <= arb_idle;
            grant   <= '0;
            last_vc <= grant_vc;
          end
        end
        default: begin
          state <= arb_idle;
          grant <= '0;
        end
      endcase
    end
  end

endmodule

//--- rtl/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo (
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  noc_pkg::flit_t in_flit,
  output logic           in_ready,
  output logic           out_valid,
  output noc_pkg::flit_t out_flit,
  input  logic           out_ready
);
  import noc_pkg::*;

  flit_t       mem [fifo_depth];
  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  fifo_count_t count;

  logic wr_fire;
  logic rd_fire;

  // Ready is not-full, so a write into a full FIFO waits even on a read.
  assign in_ready  = (count < fifo_count_t'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  assign wr_fire = in_valid && in_ready;
  assign rd_fire = out_valid && out_ready;

  function automatic fifo_ptr_t next_ptr(fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + fifo_ptr_t'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (wr_fire) begin
      wr_ptr <= next_ptr(wr_ptr);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (rd_fire) begin
      rd_ptr <= next_ptr(rd_ptr);
    end
  end

  // Occupancy.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({wr_fire, rd_fire})
        2'b10: begin
          count <= count + fifo_count_t'(1);
        end
        2'b01: begin
          count <= count - fifo_count_t'(1);
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

//--- rtl/noc_pkg.sv
package noc_pkg;

  // Router input port sizing.
  localparam int vc_count      = 4;
  localparam int fifo_depth    = 4;
  localparam int payload_width = 32;

  localparam int vc_id_width      = $clog2(vc_count);
  localparam int fifo_ptr_width   = $clog2(fifo_depth);
  localparam int fifo_count_width = $clog2(fifo_depth + 1);

  typedef logic [vc_id_width-1:0]      vc_id_t;
  typedef logic [payload_width-1:0]    payload_t;
  typedef logic [vc_count-1:0]         vc_mask_t;
  typedef logic [fifo_ptr_width-1:0]   fifo_ptr_t;
  typedef logic [fifo_count_width-1:0] fifo_count_t;

  // Single is a head and a tail in one flit.
  typedef enum logic [1:0] {
    flit_head   = 2'd0,
    flit_body   = 2'd1,
    flit_tail   = 2'd2,
    flit_single = 2'd3
  } flit_kind_t;

  typedef struct packed {
    flit_kind_t kind;
    vc_id_t     vc;
    payload_t   payload;
  } flit_t;

  typedef enum logic {
    arb_idle = 1'b0,
    arb_busy = 1'b1
  } arb_state_t;

  // Opens a packet.
  function automatic logic is_head(flit_kind_t kind);
    return (kind == flit_head) || (kind == flit_single);
  endfunction

  // Closes a packet.
  function automatic logic is_tail(flit_kind_t kind);
    return (kind == flit_tail) || (kind == flit_single);
  endfunction

endpackage
